// ==== mem_pkg.sv ====
package mem_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0]  addr_t;      // Byte address
  typedef logic [31:0]  data_t;
  typedef logic [31:0]  instr_t;
  typedef logic [3:0]   sel_byte_t;  // One enable per byte lane
  typedef logic [127:0] line_t;      // Four words, word 0 in the low bits

  // Boot region decode on the upper address half
  localparam int unsigned BMEM_SEL_ADDR_HIGH = 31;
  localparam int unsigned BMEM_SEL_ADDR_LOW  = 16;
  localparam logic [15:0] BMEM_ADDR_MATCH    = 16'h0001;

  typedef struct packed {
    addr_t addr;
    logic  req;
  } if2icache_s;

  typedef struct packed {
    instr_t instr;
    logic   ack;
  } icache2if_s;

  // MMU page walk reads
  typedef struct packed {
    addr_t paddr;
    logic  r_req;
  } mmu2dmem_s;

  typedef struct packed {
    data_t r_data;
    logic  r_valid;
  } dmem2mmu_s;

  typedef struct packed {
    addr_t     addr;
    data_t     w_data;
    sel_byte_t sel_byte;
    logic      w_en;
    logic      stb;
    logic      cyc;
  } dbus2peri_s;

  typedef struct packed {
    data_t r_data;
    logic  ack;
  } peri2dbus_s;

  // Line refill between cache and main memory
  typedef struct packed {
    addr_t addr;   // Line aligned
    logic  req;
  } icache2imem_s;

  typedef struct packed {
    line_t line;
    logic  ack;
  } imem2icache_s;

endpackage

// ==== bmem_interface.sv ====
`timescale 1ns/1ps

module bmem_interface #(
  parameter int unsigned BMEM_DEPTH = 256
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  mem_pkg::dbus2peri_s dbus2bmem_i,
  input  logic                bmem_d_sel_i,
  output mem_pkg::peri2dbus_s bmem2dbus_o,
  input  mem_pkg::if2icache_s if2bmem_i,
  input  logic                bmem_iaddr_match_i,
  output mem_pkg::icache2if_s bmem2if_o
);

  localparam int unsigned IDX_W = $clog2(BMEM_DEPTH);

  mem_pkg::data_t  mem [BMEM_DEPTH];
  logic [IDX_W-1:0] d_idx;
  logic [IDX_W-1:0] i_idx;
  logic             d_access;
  logic             i_access;
  logic             d_ack_q;
  logic             i_ack_q;
  mem_pkg::data_t   d_rdata_q;
  mem_pkg::instr_t  i_rdata_q;

  assign d_idx = dbus2bmem_i.addr[IDX_W+1:2];
  assign i_idx = if2bmem_i.addr[IDX_W+1:2];

  // A held request fires only once, the ack blocks the next edge
  assign d_access = bmem_d_sel_i & dbus2bmem_i.stb & dbus2bmem_i.cyc & ~d_ack_q;
  assign i_access = bmem_iaddr_match_i & if2bmem_i.req & ~i_ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_ack_q <= 1'b0;
      i_ack_q <= 1'b0;
    end else begin
      d_ack_q <= d_access;
      i_ack_q <= i_access;
    end
  end

  always_ff @(posedge clk) begin
    if (d_access) begin
      d_rdata_q <= mem[d_idx];  // Old word on a write
      if (dbus2bmem_i.w_en) begin
        for (int b = 0; b < 4; b++) begin
          if (dbus2bmem_i.sel_byte[b]) mem[d_idx][8*b +: 8] <= dbus2bmem_i.w_data[8*b +: 8];
        end
      end
    end
    if (i_access) i_rdata_q <= mem[i_idx];  // Fetch port is read only
  end

  assign bmem2dbus_o.r_data = d_rdata_q;
  assign bmem2dbus_o.ack    = d_ack_q;
  assign bmem2if_o.instr    = i_rdata_q;
  assign bmem2if_o.ack      = i_ack_q;

endmodule

// ==== dualport_mem.sv ====
`timescale 1ns/1ps

module dualport_mem #(
  parameter int unsigned DMEM_DEPTH = 1024
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  mem_pkg::dbus2peri_s   dbus2dmem_i,
  input  logic                  dmem_sel_i,
  output mem_pkg::peri2dbus_s   dmem2dbus_o,
  input  mem_pkg::icache2imem_s icache2imem_i,
  input  logic                  imem_sel_i,
  output mem_pkg::imem2icache_s imem2icache_o
);

  localparam int unsigned IDX_W = $clog2(DMEM_DEPTH);

  mem_pkg::data_t   mem [DMEM_DEPTH];
  logic [IDX_W-1:0] d_idx;
  logic [IDX_W-3:0] line_idx;   // Word index without the offset in the line
  logic             d_access;
  logic             i_access;
  logic             d_ack_q;
  logic             i_ack_q;
  mem_pkg::data_t   d_rdata_q;
  mem_pkg::line_t   line_q;

  // Upper address bits drop out, so accesses wrap at the depth
  assign d_idx    = dbus2dmem_i.addr[IDX_W+1:2];
  assign line_idx = icache2imem_i.addr[IDX_W+1:4];

  assign d_access = dmem_sel_i & dbus2dmem_i.stb & dbus2dmem_i.cyc & ~d_ack_q;
  assign i_access = imem_sel_i & icache2imem_i.req & ~i_ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_ack_q <= 1'b0;
      i_ack_q <= 1'b0;
    end else begin
      d_ack_q <= d_access;  // One cycle pulse per request
      i_ack_q <= i_access;
    end
  end

  always_ff @(posedge clk) begin
    if (d_access) begin
      d_rdata_q <= mem[d_idx];
      if (dbus2dmem_i.w_en) begin
        for (int b = 0; b < 4; b++) begin
          if (dbus2dmem_i.sel_byte[b]) mem[d_idx][8*b +: 8] <= dbus2dmem_i.w_data[8*b +: 8];
        end
      end
    end
    // Whole line in one access for the cache
    if (i_access) begin
      for (int w = 0; w < 4; w++) begin
        line_q[32*w +: 32] <= mem[{line_idx, 2'(w)}];
      end
    end
  end

  assign dmem2dbus_o.r_data = d_rdata_q;
  assign dmem2dbus_o.ack    = d_ack_q;
  assign imem2icache_o.line = line_q;
  assign imem2icache_o.ack  = i_ack_q;

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

module icache #(
  parameter int unsigned ICACHE_LINES = 16
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  mem_pkg::if2icache_s   if2icache_i,
  output mem_pkg::icache2if_s   icache2if_o,
  input  mem_pkg::imem2icache_s imem2icache_i,
  output mem_pkg::icache2imem_s icache2imem_o,
  input  logic                  imem_sel_i
);

  localparam int unsigned IDX_W = $clog2(ICACHE_LINES);
  localparam int unsigned TAG_W = 28 - IDX_W;  // Above index and 16 byte offset

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    RESPOND
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic [TAG_W-1:0]  tag_arr [ICACHE_LINES];
  mem_pkg::line_t    line_arr [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] valid_q;
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic [1:0]        word_off;
  logic              hit;
  mem_pkg::line_t    sel_line;

  assign idx      = if2icache_i.addr[IDX_W+3:4];
  assign tag      = if2icache_i.addr[31:IDX_W+4];
  assign word_off = if2icache_i.addr[3:2];
  assign hit      = valid_q[idx] & (tag_arr[idx] == tag);
  assign sel_line = line_arr[idx];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (imem_sel_i && if2icache_i.req) state_d = LOOKUP;
      end
      LOOKUP: begin
        if (!imem_sel_i || hit) state_d = IDLE;  // Hit answers in this cycle
        else state_d = REFILL;
      end
      REFILL: begin
        if (imem2icache_i.ack) state_d = RESPOND;
      end
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      valid_q <= '0;  // All lines start invalid
    end else begin
      state_q <= state_d;
      if (state_q == REFILL && imem2icache_i.ack) valid_q[idx] <= 1'b1;
    end
  end

  // Fill the line and tag together on refill ack
  always_ff @(posedge clk) begin
    if (state_q == REFILL && imem2icache_i.ack) begin
      line_arr[idx] <= imem2icache_i.line;
      tag_arr[idx]  <= tag;
    end
  end

  assign icache2imem_o.addr = {if2icache_i.addr[31:4], 4'b0000};
  assign icache2imem_o.req  = (state_q == REFILL);

  // Word select by bits 3:2 of the held fetch address
  assign icache2if_o.instr = sel_line[{word_off, 5'b00000} +: 32];
  assign icache2if_o.ack   = (state_q == LOOKUP && imem_sel_i && hit) || (state_q == RESPOND);

endmodule

// ==== mem_top.sv ====
`timescale 1ns/1ps

module mem_top #(
  parameter int unsigned DMEM_DEPTH   = 1024,
  parameter int unsigned BMEM_DEPTH   = 256,
  parameter int unsigned ICACHE_LINES = 16
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  mem_pkg::if2icache_s if2icache_i,
  output mem_pkg::icache2if_s icache2if_o,
  input  mem_pkg::mmu2dmem_s  mmu2dmem_i,
  output mem_pkg::dmem2mmu_s  dmem2mmu_o,
  input  mem_pkg::dbus2peri_s dbus2dmem_i,
  output mem_pkg::peri2dbus_s dmem2dbus_o,
  output mem_pkg::peri2dbus_s bmem2dbus_o,
  input  logic                dmem_sel_i,
  input  logic                bmem_sel_i
);

  mem_pkg::icache2if_s   cache2if;
  mem_pkg::icache2if_s   bmem2if;
  mem_pkg::dbus2peri_s   dmem_req;    // Data bus or MMU, after arbitration
  mem_pkg::peri2dbus_s   dmem_rsp;
  mem_pkg::icache2imem_s icache2imem;
  mem_pkg::imem2icache_s imem2icache;
  logic                  bmem_iaddr_match;
  logic                  dmem_port_sel;

  assign bmem_iaddr_match = (if2icache_i.addr[mem_pkg::BMEM_SEL_ADDR_HIGH:mem_pkg::BMEM_SEL_ADDR_LOW]
                             == mem_pkg::BMEM_ADDR_MATCH);

  // Data bus wins, MMU waits for a free cycle
  always_comb begin
    dmem_req = '0;
    if (dmem_sel_i) begin
      dmem_req = dbus2dmem_i;
    end else if (mmu2dmem_i.r_req) begin
      dmem_req.addr = mmu2dmem_i.paddr;  // Read only, no enables
      dmem_req.stb  = 1'b1;
      dmem_req.cyc  = 1'b1;
    end
  end

  assign dmem_port_sel = dmem_sel_i | mmu2dmem_i.r_req;

  // Response back to whichever master owns the port
  always_comb begin
    dmem2dbus_o = '0;
    dmem2mmu_o  = '0;
    if (dmem_sel_i) begin
      dmem2dbus_o = dmem_rsp;
    end else if (mmu2dmem_i.r_req) begin
      dmem2mmu_o.r_data  = dmem_rsp.r_data;
      dmem2mmu_o.r_valid = dmem_rsp.ack;
    end
  end

  bmem_interface #(.BMEM_DEPTH(BMEM_DEPTH)) bmem_interface_module (
    .clk                (clk),
    .arst_n_i           (arst_n_i),
    .dbus2bmem_i        (dbus2dmem_i),
    .bmem_d_sel_i       (bmem_sel_i),
    .bmem2dbus_o        (bmem2dbus_o),
    .if2bmem_i          (if2icache_i),
    .bmem_iaddr_match_i (bmem_iaddr_match),
    .bmem2if_o          (bmem2if)
  );

  dualport_mem #(.DMEM_DEPTH(DMEM_DEPTH)) dualport_mem_module (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .dbus2dmem_i   (dmem_req),
    .dmem_sel_i    (dmem_port_sel),
    .dmem2dbus_o   (dmem_rsp),
    .icache2imem_i (icache2imem),
    .imem_sel_i    (~bmem_iaddr_match),
    .imem2icache_o (imem2icache)
  );

  icache #(.ICACHE_LINES(ICACHE_LINES)) icache_module (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .if2icache_i   (if2icache_i),
    .icache2if_o   (cache2if),
    .imem2icache_i (imem2icache),
    .icache2imem_o (icache2imem),
    .imem_sel_i    (~bmem_iaddr_match)  // Cache skips the boot region
  );

  assign icache2if_o = bmem2if.ack ? bmem2if : cache2if;

endmodule

// ==== mem_top_properties.sv ====
`timescale 1ns/1ps

module mem_top_properties (
  input logic                clk,
  input logic                arst_n_i,
  input mem_pkg::if2icache_s if2icache_i,
  input mem_pkg::icache2if_s icache2if_i,
  input mem_pkg::mmu2dmem_s  mmu2dmem_i,
  input mem_pkg::dmem2mmu_s  dmem2mmu_i,
  input mem_pkg::dbus2peri_s dbus2dmem_i,
  input mem_pkg::peri2dbus_s dmem2dbus_i,
  input mem_pkg::peri2dbus_s bmem2dbus_i,
  input logic                dmem_sel_i
);

  int unsigned assert_fails = 0;  // Failed assertion count

  // One cycle acks while the request is still held
  dmem_ack_once: assert property (@(posedge clk) disable iff (!arst_n_i)
    dmem2dbus_i.ack && dbus2dmem_i.stb |=> !dmem2dbus_i.ack)
    else begin
      $error("dmem2dbus_o.ack longer than one cycle");
      assert_fails++;
    end

  bmem_ack_once: assert property (@(posedge clk) disable iff (!arst_n_i)
    bmem2dbus_i.ack && dbus2dmem_i.stb |=> !bmem2dbus_i.ack)
    else begin
      $error("bmem2dbus_o.ack longer than one cycle");
      assert_fails++;
    end

  fetch_ack_once: assert property (@(posedge clk) disable iff (!arst_n_i)
    icache2if_i.ack && if2icache_i.req |=> !icache2if_i.ack)
    else begin
      $error("icache2if_o.ack longer than one cycle");
      assert_fails++;
    end

  mmu_valid_once: assert property (@(posedge clk) disable iff (!arst_n_i)
    dmem2mmu_i.r_valid && mmu2dmem_i.r_req |=> !dmem2mmu_i.r_valid)
    else begin
      $error("dmem2mmu_o.r_valid longer than one cycle");
      assert_fails++;
    end

  dbus_acks_apart: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(dmem2dbus_i.ack && bmem2dbus_i.ack))
    else begin
      $error("both data bus acks high together");
      assert_fails++;
    end

  fetch_ack_with_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    icache2if_i.ack |-> if2icache_i.req)
    else begin
      $error("fetch ack without a fetch request");
      assert_fails++;
    end

  // MMU response only for a request made while the data bus was off the port
  mmu_waits_for_dbus: assert property (@(posedge clk) disable iff (!arst_n_i)
    dmem2mmu_i.r_valid |-> $past(!dmem_sel_i && mmu2dmem_i.r_req))
    else begin
      $error("dmem2mmu_o.r_valid for a request made while the data bus was selected");
      assert_fails++;
    end

endmodule

bind mem_top mem_top_properties props0 (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .if2icache_i (if2icache_i),
  .icache2if_i (icache2if_o),
  .mmu2dmem_i  (mmu2dmem_i),
  .dmem2mmu_i  (dmem2mmu_o),
  .dbus2dmem_i (dbus2dmem_i),
  .dmem2dbus_i (dmem2dbus_o),
  .bmem2dbus_i (bmem2dbus_o),
  .dmem_sel_i  (dmem_sel_i)
);

// ==== tb_mem_top.sv ====
`timescale 1ns/1ps

module tb_mem_top;

  localparam int unsigned ACK_TIMEOUT = 50;  // Cycles per wait

  logic                clk;
  logic                arst_n_i;
  mem_pkg::if2icache_s if2icache;
  mem_pkg::icache2if_s icache2if;
  mem_pkg::mmu2dmem_s  mmu2dmem;
  mem_pkg::dmem2mmu_s  dmem2mmu;
  mem_pkg::dbus2peri_s dbus_req;
  mem_pkg::peri2dbus_s dmem2dbus;
  mem_pkg::peri2dbus_s bmem2dbus;
  logic                dmem_sel;
  logic                bmem_sel;
  logic [31:0]         rng_state;

  mem_top dut0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .if2icache_i (if2icache),
    .icache2if_o (icache2if),
    .mmu2dmem_i  (mmu2dmem),
    .dmem2mmu_o  (dmem2mmu),
    .dbus2dmem_i (dbus_req),
    .dmem2dbus_o (dmem2dbus),
    .bmem2dbus_o (bmem2dbus),
    .dmem_sel_i  (dmem_sel),
    .bmem_sel_i  (bmem_sel)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Boot region decode, same rule as the external address decoder
  function automatic logic in_boot_region(input mem_pkg::addr_t addr);
    return addr[mem_pkg::BMEM_SEL_ADDR_HIGH:mem_pkg::BMEM_SEL_ADDR_LOW]
           == mem_pkg::BMEM_ADDR_MATCH;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // Stop on the first failed bound assertion
  always @(negedge clk) begin
    if (dut0.props0.assert_fails != 0) fail_run("assertion failed in mem_top_properties");
  end

  task automatic check_data(input string name, input mem_pkg::data_t got,
                            input mem_pkg::data_t exp);
    if (got !== exp) fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_instr(input mem_pkg::instr_t got, input mem_pkg::instr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] icache2if_o.instr: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_mmu(input mem_pkg::data_t got, input mem_pkg::data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] dmem2mmu_o.r_data: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic insert_idle_cycles();
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) @(posedge clk);  // 0 to 3 idle cycles
  endtask

  task automatic dbus_access(input mem_pkg::addr_t addr, input mem_pkg::data_t wdata,
                             input mem_pkg::sel_byte_t mask, input logic write,
                             output mem_pkg::data_t rdata);
    mem_pkg::peri2dbus_s rsp;
    int unsigned         cnt;
    logic                boot;
    boot = in_boot_region(addr);
    rsp  = '0;
    cnt  = 0;
    @(posedge clk);
    dbus_req.addr     <= addr;
    dbus_req.w_data   <= wdata;
    dbus_req.sel_byte <= write ? mask : 4'h0;
    dbus_req.w_en     <= write;
    dbus_req.stb      <= 1'b1;
    dbus_req.cyc      <= 1'b1;
    dmem_sel          <= !boot;
    bmem_sel          <= boot;
    while (!rsp.ack && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      rsp = boot ? bmem2dbus : dmem2dbus;
      cnt++;
    end
    if (!rsp.ack) begin
      fail_run(boot ? "no acknowledge from bmem2dbus_o" : "no acknowledge from dmem2dbus_o");
    end
    rdata = rsp.r_data;
    @(posedge clk);
    dbus_req.stb  <= 1'b0;  // Bus idle for at least one cycle
    dbus_req.cyc  <= 1'b0;
    dbus_req.w_en <= 1'b0;
    dmem_sel      <= 1'b0;
    bmem_sel      <= 1'b0;
  endtask

  task automatic fetch(input mem_pkg::addr_t addr, output mem_pkg::instr_t instr);
    int unsigned cnt;
    cnt = 0;
    @(posedge clk);
    if2icache.addr <= addr;
    if2icache.req  <= 1'b1;
    do begin
      @(negedge clk);
      cnt++;
    end while (!icache2if.ack && cnt < ACK_TIMEOUT);
    if (!icache2if.ack) fail_run("no acknowledge from icache2if_o");
    instr = icache2if.instr;
    @(posedge clk);
    if2icache.req <= 1'b0;
  endtask

  task automatic wait_mmu_valid(output mem_pkg::data_t rdata);
    int unsigned cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!dmem2mmu.r_valid && cnt < ACK_TIMEOUT);
    if (!dmem2mmu.r_valid) fail_run("no acknowledge from dmem2mmu_o");
    rdata = dmem2mmu.r_data;
    @(posedge clk);
    mmu2dmem.r_req <= 1'b0;
  endtask

  task automatic mmu_read(input mem_pkg::addr_t addr, output mem_pkg::data_t rdata);
    @(posedge clk);
    mmu2dmem.paddr <= addr;
    mmu2dmem.r_req <= 1'b1;
    wait_mmu_valid(rdata);
  endtask

  // MMU and data bus start on the same edge, data bus must finish first
  task automatic mmu_beside_dbus(input mem_pkg::addr_t mmu_addr,
                                 input mem_pkg::addr_t dbus_addr,
                                 output mem_pkg::data_t mmu_data,
                                 output mem_pkg::data_t dbus_data);
    int unsigned cnt;
    cnt = 0;
    @(posedge clk);
    mmu2dmem.paddr    <= mmu_addr;
    mmu2dmem.r_req    <= 1'b1;
    dbus_req.addr     <= dbus_addr;
    dbus_req.sel_byte <= 4'h0;
    dbus_req.w_en     <= 1'b0;
    dbus_req.stb      <= 1'b1;
    dbus_req.cyc      <= 1'b1;
    dmem_sel          <= 1'b1;
    do begin
      @(negedge clk);
      if (dmem2mmu.r_valid) fail_run("MMU read completed before the data bus read");
      cnt++;
    end while (!dmem2dbus.ack && cnt < ACK_TIMEOUT);
    if (!dmem2dbus.ack) fail_run("no acknowledge from dmem2dbus_o");
    dbus_data = dmem2dbus.r_data;
    @(posedge clk);
    dbus_req.stb <= 1'b0;
    dbus_req.cyc <= 1'b0;
    dmem_sel     <= 1'b0;
    wait_mmu_valid(mmu_data);
  endtask

  // Next non comment line of the cases file
  task automatic read_case(input int fd, output bit found, output logic [7:0] op,
                           output mem_pkg::addr_t addr, output mem_pkg::data_t value,
                           output mem_pkg::sel_byte_t mask);
    string text;
    int    n;
    found = 1'b0;
    while (!found && !$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (n > 1 && text.getc(0) != "#") begin
        n = $sscanf(text, "%c %h %h %h", op, addr, value, mask);
        if (n != 4) fail_run({"malformed line in mem_cases.txt: ", text});
        found = 1'b1;
      end
    end
  endtask

  initial begin
    int                 fd;
    bit                 found;
    logic [7:0]         op;
    logic [7:0]         op2;
    mem_pkg::addr_t     addr;
    mem_pkg::addr_t     addr2;
    mem_pkg::data_t     value;
    mem_pkg::data_t     value2;
    mem_pkg::data_t     rdata;
    mem_pkg::data_t     rdata2;
    mem_pkg::sel_byte_t mask;
    mem_pkg::sel_byte_t mask2;
    mem_pkg::instr_t    instr;
    int unsigned        n_cases;
    if2icache = '0;
    mmu2dmem  = '0;
    dbus_req  = '0;
    dmem_sel  = 1'b0;
    bmem_sel  = 1'b0;
    arst_n_i  = 1'b0;
    rng_state = 32'h627c;
    n_cases   = 0;
    repeat (16) @(posedge clk);
    arst_n_i <= 1'b1;
    fd = $fopen("mem_cases.txt", "r");
    if (fd == 0) fail_run("cannot open mem_cases.txt");
    read_case(fd, found, op, addr, value, mask);
    while (found) begin
      insert_idle_cycles();
      case (op)
        "W": dbus_access(addr, value, mask, 1'b1, rdata);
        "R": begin
          dbus_access(addr, '0, '0, 1'b0, rdata);
          check_data(in_boot_region(addr) ? "bmem2dbus_o.r_data" : "dmem2dbus_o.r_data",
                     rdata, value);
        end
        "F": begin
          fetch(addr, instr);
          check_instr(instr, value);
        end
        "M": begin
          mmu_read(addr, rdata);
          check_mmu(rdata, value);
        end
        "C": begin
          read_case(fd, found, op2, addr2, value2, mask2);
          if (!found || op2 != "R") fail_run("C line in mem_cases.txt has no R line after it");
          mmu_beside_dbus(addr, addr2, rdata, rdata2);
          check_data("dmem2dbus_o.r_data", rdata2, value2);
          check_mmu(rdata, value);
        end
        default: fail_run("unknown operation in mem_cases.txt");
      endcase
      n_cases++;
      read_case(fd, found, op, addr, value, mask);
    end
    $fclose(fd);
    repeat (2) @(negedge clk);
    if (n_cases > 0 && dut0.props0.assert_fails == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("no operations in mem_cases.txt or a bound assertion failed");
    end
  end

endmodule

// ==== mem_cases.txt ====
# op addr data mask: W write, R read, F fetch, M MMU read, C MMU read beside the next R line
# addr, data and mask in hex; data is the expected value for R, F, M and C
W 00000000 11223344 f
W 00000000 aabbccdd 5
R 00000000 11bb33dd 0
W 00000004 cafef00d f
W 00000004 00001200 2
R 00000004 cafe120d 0
W 00000008 00000013 f
W 0000000c 00500093 f
W 0000000c ffffff00 0
R 0000000c 00500093 0
W 00000100 deadbeef f
W 00000104 0badc0de f
W 00000200 76543210 f
F 00000004 cafe120d 0
F 00000004 cafe120d 0
F 00000000 11bb33dd 0
F 00000008 00000013 0
F 0000000c 00500093 0
F 00000100 deadbeef 0
F 00000000 11bb33dd 0
F 00000104 0badc0de 0
F 00000004 cafe120d 0
W 00010000 00000297 f
W 00010004 12345678 f
W 00010004 0000ab00 2
R 00010004 1234ab78 0
R 00010000 00000297 0
R 00000000 11bb33dd 0
F 00010000 00000297 0
F 00010004 1234ab78 0
M 00000100 deadbeef 0
M 00000004 cafe120d 0
C 00000200 76543210 0
R 00000104 0badc0de 0
C 0000000c 00500093 0
R 00000008 00000013 0

// ==== verilog.f ====
mem_pkg.sv
bmem_interface.sv
dualport_mem.sv
icache.sv
mem_top.sv
mem_top_properties.sv
tb_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
